// ==== source/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    localparam int KEY_WIDTH = 16;

    typedef logic [KEY_WIDTH-1:0] key_code_t;  // one-cold, a low line is a pressed key

    localparam key_code_t KEY_IDLE  = '1;
    localparam key_code_t KEY_0     = 16'b1110_1111_1111_1111;
    localparam key_code_t KEY_1     = 16'b1111_1011_1111_1111;
    localparam key_code_t KEY_2     = 16'b1111_1101_1111_1111;
    localparam key_code_t KEY_3     = 16'b1111_1110_1111_1111;
    localparam key_code_t KEY_4     = 16'b1111_1111_1110_1111;
    localparam key_code_t KEY_5     = 16'b1111_1111_1101_1111;
    localparam key_code_t KEY_6     = 16'b1111_1111_1011_1111;
    localparam key_code_t KEY_7     = 16'b1111_1111_1111_1110;
    localparam key_code_t KEY_8     = 16'b1111_1111_1111_1101;
    localparam key_code_t KEY_9     = 16'b1111_1111_1111_1011;
    localparam key_code_t KEY_PLUS  = 16'b0111_1111_1111_1111;
    localparam key_code_t KEY_MINUS = 16'b1111_0111_1111_1111;
    localparam key_code_t KEY_MUL   = 16'b1111_1111_0111_1111;
    localparam key_code_t KEY_EQL   = 16'b1011_1111_1111_1111;

    localparam int DIGIT_W = 4;

    typedef logic [DIGIT_W-1:0] digit_t;

    localparam digit_t SIGN_CODE = 4'd10;  // drawn as a minus sign

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } op_t;

    typedef enum logic [1:0] {
        KIND_DIGIT,
        KIND_OP,
        KIND_EQL,
        KIND_NONE
    } key_kind_t;

endpackage

`default_nettype wire

// ==== source/key_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_scanner (
    input  wire logic                clk_in,
    input  wire logic                rst_n_in,
    input  wire calc_pkg::key_code_t key_i,
    output logic                     press_o,
    output calc_pkg::key_kind_t      kind_o,
    output calc_pkg::digit_t         digit_o,
    output calc_pkg::op_t            op_o
);
    import calc_pkg::*;

    key_code_t key_q1;
    key_code_t key_q2;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            key_q1  <= KEY_IDLE;
            key_q2  <= KEY_IDLE;
            press_o <= 1'b0;
        end else begin
            key_q1  <= key_i;
            key_q2  <= key_q1;
            press_o <= (&key_q2) & ~(&key_q1);  // idle to pressed edge
        end
    end

    always_comb begin
        kind_o  = KIND_DIGIT;
        digit_o = '0;
        op_o    = OP_ADD;
        case (key_q2)
            KEY_0:     digit_o = 4'd0;
            KEY_1:     digit_o = 4'd1;
            KEY_2:     digit_o = 4'd2;
            KEY_3:     digit_o = 4'd3;
            KEY_4:     digit_o = 4'd4;
            KEY_5:     digit_o = 4'd5;
            KEY_6:     digit_o = 4'd6;
            KEY_7:     digit_o = 4'd7;
            KEY_8:     digit_o = 4'd8;
            KEY_9:     digit_o = 4'd9;
            KEY_PLUS:  kind_o  = KIND_OP;
            KEY_MINUS: begin
                kind_o = KIND_OP;
                op_o   = OP_SUB;
            end
            KEY_MUL:   begin
                kind_o = KIND_OP;
                op_o   = OP_MUL;
            end
            KEY_EQL:   kind_o  = KIND_EQL;
            default:   kind_o  = KIND_NONE;  // chords and unused keys
        endcase
    end

endmodule

`default_nettype wire

// ==== source/operand_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_entry #(
    parameter  int OPERAND_DIGITS = 2,
    localparam int OPERAND_W      = $clog2(10 ** OPERAND_DIGITS),
    localparam int ENTRY_W        = OPERAND_DIGITS * calc_pkg::DIGIT_W,
    localparam int CNT_W          = $clog2(OPERAND_DIGITS + 1)
) (
    input  wire logic                 clk_in,
    input  wire logic                 rst_n_in,
    input  wire logic                 press_i,
    input  wire calc_pkg::key_kind_t  kind_i,
    input  wire calc_pkg::digit_t     digit_i,
    input  wire calc_pkg::op_t        op_i,
    input  wire logic                 conv_done_i,
    output logic                      start_o,
    output logic [OPERAND_W-1:0]      num_a_o,
    output logic [OPERAND_W-1:0]      num_b_o,
    output calc_pkg::op_t             op_sel_o,
    output logic [ENTRY_W-1:0]        entry_digits_o,
    output logic [CNT_W-1:0]          entry_count_o,
    output logic                      show_result_o,
    output logic                      new_entry_o
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        FIRST,     // no digit of operand a yet
        OPERATOR,  // operand a has digits, operator allowed
        SECOND,
        RESULT
    } state_t;

    state_t                state;
    logic                  is_digit;
    logic                  entry_full;
    logic [OPERAND_W-1:0]  digit_ext;
    logic [ENTRY_W-1:0]    shifted_digits;

    assign is_digit       = (kind_i == KIND_DIGIT);
    assign entry_full     = (entry_count_o == CNT_W'(OPERAND_DIGITS));
    assign digit_ext      = OPERAND_W'(digit_i);
    assign shifted_digits = (entry_digits_o << DIGIT_W) | ENTRY_W'(digit_i);  // new digit at right
    assign show_result_o  = (state == RESULT);

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state          <= FIRST;
            num_a_o        <= '0;
            num_b_o        <= '0;
            op_sel_o       <= OP_ADD;
            entry_digits_o <= '0;
            entry_count_o  <= '0;
            start_o        <= 1'b0;
            new_entry_o    <= 1'b0;
        end else begin
            start_o     <= 1'b0;
            new_entry_o <= 1'b0;
            if (press_i) begin
                case (state)
                    FIRST, RESULT: begin
                        // a result is left alone until conversion is done
                        if (is_digit && (state == FIRST || conv_done_i)) begin
                            num_a_o        <= digit_ext;
                            entry_digits_o <= ENTRY_W'(digit_i);
                            entry_count_o  <= CNT_W'(1);
                            new_entry_o    <= (state == RESULT);
                            state          <= OPERATOR;
                        end
                    end
                    OPERATOR: begin
                        if (is_digit && !entry_full) begin
                            num_a_o        <= num_a_o * OPERAND_W'(10) + digit_ext;
                            entry_digits_o <= shifted_digits;
                            entry_count_o  <= entry_count_o + 1'b1;
                        end else if (kind_i == KIND_OP) begin
                            op_sel_o       <= op_i;
                            num_b_o        <= '0;
                            entry_digits_o <= '0;
                            entry_count_o  <= '0;
                            state          <= SECOND;
                        end
                    end
                    SECOND: begin
                        if (is_digit && !entry_full) begin
                            num_b_o        <= num_b_o * OPERAND_W'(10) + digit_ext;
                            entry_digits_o <= shifted_digits;
                            entry_count_o  <= entry_count_o + 1'b1;
                        end else if (kind_i == KIND_EQL && entry_count_o != '0) begin
                            start_o <= 1'b1;
                            state   <= RESULT;
                        end
                    end
                    default: state <= FIRST;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/result_converter.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_converter #(
    parameter  int OPERAND_DIGITS = 2,
    localparam int DISPLAY_DIGITS = 2 * OPERAND_DIGITS,
    localparam int OPERAND_W      = $clog2(10 ** OPERAND_DIGITS),
    localparam int RES_W          = $clog2(10 ** DISPLAY_DIGITS),
    localparam int POS_W          = $clog2(DISPLAY_DIGITS)
) (
    input  wire logic                                clk_in,
    input  wire logic                                rst_n_in,
    input  wire logic                                start_i,
    input  wire logic                                new_entry_i,
    input  wire logic [OPERAND_W-1:0]                num_a_i,
    input  wire logic [OPERAND_W-1:0]                num_b_i,
    input  wire calc_pkg::op_t                       op_sel_i,
    output calc_pkg::digit_t [DISPLAY_DIGITS-1:0]    res_digits_o,
    output logic                                     negative_o,
    output logic                                     done_o
);
    import calc_pkg::*;

    logic [RES_W-1:0] a_ext;
    logic [RES_W-1:0] b_ext;
    logic [RES_W-1:0] magnitude;
    logic [RES_W-1:0] remainder;
    logic [RES_W-1:0] step;
    logic [POS_W-1:0] pos;
    logic             a_below_b;
    logic             busy;

    function automatic logic [RES_W-1:0] pow10(input logic [POS_W-1:0] p);
        logic [RES_W-1:0] v;
        v = RES_W'(1);
        for (int i = 0; i < DISPLAY_DIGITS - 1; i++) begin
            if (i < int'(p)) begin
                v = v * RES_W'(10);
            end
        end
        return v;
    endfunction

    assign a_ext     = RES_W'(num_a_i);
    assign b_ext     = RES_W'(num_b_i);
    assign a_below_b = (num_a_i < num_b_i);
    assign step      = pow10(pos);  // weight of the digit being counted

    always_comb begin
        case (op_sel_i)
            OP_SUB:  magnitude = a_below_b ? (b_ext - a_ext) : (a_ext - b_ext);
            OP_MUL:  magnitude = a_ext * b_ext;
            default: magnitude = a_ext + b_ext;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            remainder    <= '0;
            res_digits_o <= '0;
            pos          <= '0;
            negative_o   <= 1'b0;
            busy         <= 1'b0;
            done_o       <= 1'b0;
        end else if (start_i) begin
            remainder    <= magnitude;
            res_digits_o <= '0;
            pos          <= POS_W'(DISPLAY_DIGITS - 1);  // start at the top position
            negative_o   <= (op_sel_i == OP_SUB) && a_below_b;
            busy         <= 1'b1;
            done_o       <= 1'b0;
        end else begin
            if (new_entry_i) begin
                done_o <= 1'b0;
            end
            if (busy) begin
                if (remainder == '0) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end else if (remainder >= step) begin
                    remainder         <= remainder - step;
                    res_digits_o[pos] <= res_digits_o[pos] + 4'd1;
                end else begin
                    pos <= pos - 1'b1;  // never below 0, remainder is zero by then
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/display_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_select #(
    parameter  int OPERAND_DIGITS = 2,
    localparam int DISPLAY_DIGITS = 2 * OPERAND_DIGITS,
    localparam int ENTRY_W        = OPERAND_DIGITS * calc_pkg::DIGIT_W,
    localparam int CNT_W          = $clog2(OPERAND_DIGITS + 1),
    localparam int POS_W          = $clog2(DISPLAY_DIGITS)
) (
    input  wire logic                                  show_result_i,
    input  wire logic [ENTRY_W-1:0]                    entry_digits_i,
    input  wire logic [CNT_W-1:0]                      entry_count_i,
    input  wire calc_pkg::digit_t [DISPLAY_DIGITS-1:0] res_digits_i,
    input  wire logic                                  negative_i,
    input  wire logic                                  done_i,
    output calc_pkg::digit_t [DISPLAY_DIGITS-1:0]      digits_o,
    output logic [DISPLAY_DIGITS-1:0]                  seg_en_o
);
    import calc_pkg::*;

    digit_t [DISPLAY_DIGITS-1:0] entry_view;
    logic   [POS_W-1:0]          msd;

    always_comb begin
        entry_view = '0;
        for (int i = 0; i < OPERAND_DIGITS; i++) begin
            entry_view[i] = entry_digits_i[i*DIGIT_W +: DIGIT_W];
        end

        msd = '0;  // all zero still shows position 0
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            if (res_digits_i[i] != '0) begin
                msd = POS_W'(i);
            end
        end

        if (show_result_i) begin
            digits_o = res_digits_i;
            for (int i = 0; i < DISPLAY_DIGITS; i++) begin
                seg_en_o[i] = done_i && (i <= int'(msd));
                if (negative_i && (i == int'(msd) + 1)) begin
                    digits_o[i] = SIGN_CODE;  // sign just left of msd
                    seg_en_o[i] = done_i;
                end
            end
        end else begin
            digits_o = entry_view;
            for (int i = 0; i < DISPLAY_DIGITS; i++) begin
                seg_en_o[i] = (i < int'(entry_count_i));
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/calculator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module calculator_top #(
    parameter  int OPERAND_DIGITS = 2,
    localparam int DISPLAY_DIGITS = 2 * OPERAND_DIGITS,
    localparam int OPERAND_W      = $clog2(10 ** OPERAND_DIGITS),
    localparam int ENTRY_W        = OPERAND_DIGITS * calc_pkg::DIGIT_W,
    localparam int CNT_W          = $clog2(OPERAND_DIGITS + 1)
) (
    input  wire logic                             clk_in,
    input  wire logic                             rst_n_in,
    input  wire calc_pkg::key_code_t              key_i,
    output calc_pkg::digit_t [DISPLAY_DIGITS-1:0] digits_o,
    output logic [DISPLAY_DIGITS-1:0]             seg_en_o,
    output logic                                  calc_done_o
);
    import calc_pkg::*;

    logic                        press;
    key_kind_t                   kind;
    digit_t                      digit;
    op_t                         op;
    logic                        start;
    logic [OPERAND_W-1:0]        num_a;
    logic [OPERAND_W-1:0]        num_b;
    op_t                         op_sel;
    logic [ENTRY_W-1:0]          entry_digits;
    logic [CNT_W-1:0]            entry_count;
    logic                        show_result;
    logic                        new_entry;
    digit_t [DISPLAY_DIGITS-1:0] res_digits;
    logic                        negative;

    key_scanner i_key_scanner (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .key_i    (key_i),
        .press_o  (press),
        .kind_o   (kind),
        .digit_o  (digit),
        .op_o     (op)
    );

    operand_entry #(
        .OPERAND_DIGITS (OPERAND_DIGITS)
    ) i_operand_entry (
        .clk_in         (clk_in),
        .rst_n_in       (rst_n_in),
        .press_i        (press),
        .kind_i         (kind),
        .digit_i        (digit),
        .op_i           (op),
        .conv_done_i    (calc_done_o),
        .start_o        (start),
        .num_a_o        (num_a),
        .num_b_o        (num_b),
        .op_sel_o       (op_sel),
        .entry_digits_o (entry_digits),
        .entry_count_o  (entry_count),
        .show_result_o  (show_result),
        .new_entry_o    (new_entry)
    );

    result_converter #(
        .OPERAND_DIGITS (OPERAND_DIGITS)
    ) i_result_converter (
        .clk_in       (clk_in),
        .rst_n_in     (rst_n_in),
        .start_i      (start),
        .new_entry_i  (new_entry),
        .num_a_i      (num_a),
        .num_b_i      (num_b),
        .op_sel_i     (op_sel),
        .res_digits_o (res_digits),
        .negative_o   (negative),
        .done_o       (calc_done_o)
    );

    display_select #(
        .OPERAND_DIGITS (OPERAND_DIGITS)
    ) i_display_select (
        .show_result_i  (show_result),
        .entry_digits_i (entry_digits),
        .entry_count_i  (entry_count),
        .res_digits_i   (res_digits),
        .negative_i     (negative),
        .done_i         (calc_done_o),
        .digits_o       (digits_o),
        .seg_en_o       (seg_en_o)
    );

endmodule

`default_nettype wire

// ==== bench/calculator_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module calculator_properties #(
    parameter  int OPERAND_DIGITS = 2,
    localparam int DISPLAY_DIGITS = 2 * OPERAND_DIGITS
) (
    input wire logic                                  clk_in,
    input wire logic                                  rst_n_in,
    input wire calc_pkg::key_code_t                   key_i,
    input wire calc_pkg::digit_t [DISPLAY_DIGITS-1:0] digits_i,
    input wire logic [DISPLAY_DIGITS-1:0]             seg_en_i,
    input wire logic                                  calc_done_i
);
    import calc_pkg::*;

    logic key_seen;
    logic digits_legal;
    int   assert_failures = 0;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            key_seen <= 1'b0;
        end else if (key_i != KEY_IDLE) begin
            key_seen <= 1'b1;
        end
    end

    always_comb begin
        digits_legal = 1'b1;
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            if (digits_i[i] > SIGN_CODE) begin
                digits_legal = 1'b0;
            end
        end
    end

    blank_after_reset: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        !key_seen |-> (seg_en_i == '0)
    ) else begin
        $error("display enabled before any key was pressed");
        assert_failures++;
    end

    digit_code_range: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        digits_legal
    ) else begin
        $error("digit code above the sign code on the display");
        assert_failures++;
    end

    done_hold: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        (calc_done_i && (key_i == KEY_IDLE)) |=> calc_done_i
    ) else begin
        $error("done dropped while no key was pressed");
        assert_failures++;
    end

endmodule

bind calculator_top calculator_properties #(
    .OPERAND_DIGITS (OPERAND_DIGITS)
) i_properties (
    .clk_in      (clk_in),
    .rst_n_in    (rst_n_in),
    .key_i       (key_i),
    .digits_i    (digits_o),
    .seg_en_i    (seg_en_o),
    .calc_done_i (calc_done_o)
);

`default_nettype wire

// ==== bench/calculator_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module calculator_checker #(
    parameter  int DISPLAY_DIGITS = 4,
    localparam int DW             = 4 * DISPLAY_DIGITS
) (
    input  wire logic                      clk_in,
    input  wire logic                      rst_n_in,
    input  wire calc_pkg::key_code_t       key_i,
    input  wire logic [DW-1:0]             digits_i,
    input  wire logic [DISPLAY_DIGITS-1:0] seg_en_i,
    input  wire logic                      done_i,
    input  wire logic [8*12-1:0]           test_name_i,
    input  wire logic                      check_entry_i,
    input  wire logic [DW-1:0]             exp_digits_i,
    input  wire logic [DISPLAY_DIGITS-1:0] exp_en_i,
    input  wire logic                      exp_done_i,
    output int                             tests_passed_o,
    output int                             tests_failed_o,
    output int                             errors_o
);
    import calc_pkg::*;

    key_code_t key_prev;
    logic      done_prev;
    int        settle;       // cycles left until the entry display is sampled
    int        test_errors;

    task automatic compare_field(input string what, input logic [DW-1:0] expected,
                                 input logic [DW-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %0s %0s: expected %h, actual %h",
                     test_name_i, what, expected, actual);
            errors_o++;
            test_errors++;
        end
    endtask

    always @(posedge clk_in) begin
        if (!rst_n_in) begin
            key_prev       = KEY_IDLE;
            done_prev      = 1'b0;
            settle         = 0;
            test_errors    = 0;
            tests_passed_o = 0;
            tests_failed_o = 0;
            errors_o       = 0;
        end else begin
            if (key_prev != KEY_IDLE && key_i == KEY_IDLE) begin
                settle = 4;  // key just released
            end else if (settle > 0) begin
                settle--;
                if (settle == 0 && check_entry_i) begin
                    compare_field("digits", exp_digits_i, digits_i);
                    compare_field("enable", DW'(exp_en_i), DW'(seg_en_i));
                    compare_field("done", DW'(exp_done_i), DW'(done_i));
                end
            end
            if (done_i && !done_prev) begin
                compare_field("result digits", exp_digits_i, digits_i);
                compare_field("result enable", DW'(exp_en_i), DW'(seg_en_i));
                if (test_errors == 0) begin
                    $display("test %0s: ok", test_name_i);
                    tests_passed_o++;
                end else begin
                    $display("test %0s: %0d mismatches", test_name_i, test_errors);
                    tests_failed_o++;
                end
                test_errors = 0;
            end
            key_prev  = key_i;
            done_prev = done_i;
        end
    end

endmodule

`default_nettype wire

// ==== bench/calculator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module calculator_tb;
    import calc_pkg::*;

    localparam int OPERAND_DIGITS = 2;
    localparam int DISPLAY_DIGITS = 2 * OPERAND_DIGITS;
    localparam int DW             = 4 * DISPLAY_DIGITS;
    localparam int N_TESTS        = 11;
    localparam int TIMEOUT_CYCLES = N_TESTS * 300;
    localparam logic [DW-1:0] ENTRY_MASK = DW'((64'd1 << (4 * OPERAND_DIGITS)) - 64'd1);
    localparam key_code_t KEY_STRAY = 16'hDFFF;  // line with no key on it

    // digits in typing order with the first one in the top nibble
    typedef struct packed {
        logic [8*12-1:0]     name;
        logic [1:0]          a_n;
        logic [11:0]         a_keys;
        op_t                 op;
        logic [1:0]          b_n;
        logic [11:0]         b_keys;
        logic [2:0]          extra;  // op before a, stray before a, equals before b
        logic [DW-1:0]       exp_digits;
        logic [DISPLAY_DIGITS-1:0] exp_en;
    } test_t;

    logic                      clk_in;
    logic                      rst_n_in;
    key_code_t                 key_i;
    logic [DW-1:0]             digits;
    logic [DISPLAY_DIGITS-1:0] seg_en;
    logic                      calc_done;
    logic [8*12-1:0]           test_name;
    logic                      check_entry;
    logic [DW-1:0]             exp_digits;
    logic [DISPLAY_DIGITS-1:0] exp_en;
    logic                      exp_done;
    int                        tests_passed;
    int                        tests_failed;
    int                        errors;
    int                        cycle_count;
    test_t                     tests [N_TESTS];
    int                        m_phase;  // 0 no entry, 1 operand a, 2 operand b, 3 result
    int                        m_count;
    logic                      m_done;
    logic [DW-1:0]             m_digits;
    logic [DW-1:0]             m_res_digits;
    logic [DISPLAY_DIGITS-1:0] m_res_en;
    logic [DW-1:0]             pending_digits;
    logic [DISPLAY_DIGITS-1:0] pending_en;

    calculator_top #(
        .OPERAND_DIGITS (OPERAND_DIGITS)
    ) i_dut (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .key_i       (key_i),
        .digits_o    (digits),
        .seg_en_o    (seg_en),
        .calc_done_o (calc_done)
    );

    calculator_checker #(
        .DISPLAY_DIGITS (DISPLAY_DIGITS)
    ) i_checker (
        .clk_in         (clk_in),
        .rst_n_in       (rst_n_in),
        .key_i          (key_i),
        .digits_i       (digits),
        .seg_en_i       (seg_en),
        .done_i         (calc_done),
        .test_name_i    (test_name),
        .check_entry_i  (check_entry),
        .exp_digits_i   (exp_digits),
        .exp_en_i       (exp_en),
        .exp_done_i     (exp_done),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .errors_o       (errors)
    );

    always #20 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic key_code_t digit_key(input int d);
        case (d)
            0:       return KEY_0;
            1:       return KEY_1;
            2:       return KEY_2;
            3:       return KEY_3;
            4:       return KEY_4;
            5:       return KEY_5;
            6:       return KEY_6;
            7:       return KEY_7;
            8:       return KEY_8;
            default: return KEY_9;
        endcase
    endfunction

    function automatic key_code_t op_key(input op_t op);
        case (op)
            OP_SUB:  return KEY_MINUS;
            OP_MUL:  return KEY_MUL;
            default: return KEY_PLUS;
        endcase
    endfunction

    // expected display after a key
    task automatic apply_rules(input key_code_t key);
        int d;
        d = -1;
        for (int i = 0; i < 10; i++) begin
            if (key == digit_key(i)) begin
                d = i;
            end
        end
        check_entry = 1'b1;
        if (d >= 0) begin
            if (m_phase == 0 || m_phase == 3) begin
                m_digits = DW'(d);
                m_count  = 1;
                m_phase  = 1;
                m_done   = 1'b0;
            end else if (m_count < OPERAND_DIGITS) begin
                m_digits = ((m_digits << 4) | DW'(d)) & ENTRY_MASK;
                m_count++;
            end
        end else if ((key == KEY_PLUS || key == KEY_MINUS || key == KEY_MUL) && m_phase == 1) begin
            m_digits = '0;
            m_count  = 0;
            m_phase  = 2;
        end else if (key == KEY_EQL && m_phase == 2 && m_count > 0) begin
            m_phase      = 3;
            m_res_digits = pending_digits;
            m_res_en     = pending_en;
            m_done       = 1'b1;
            check_entry  = 1'b0;  // checked when done rises
        end
        if (m_phase == 3) begin
            exp_digits = m_res_digits;
            exp_en     = m_res_en;
        end else begin
            exp_digits = m_digits;
            exp_en     = DISPLAY_DIGITS'((1 << m_count) - 1);
        end
        exp_done = m_done;
    endtask

    task automatic press_key(input key_code_t key);
        int gap;
        @(posedge clk_in);
        #2;
        apply_rules(key);
        key_i = key;
        repeat (4) @(posedge clk_in);
        #2;
        key_i = KEY_IDLE;
        gap = 4 + int'($urandom % 5);
        repeat (gap) @(posedge clk_in);
    endtask

    task automatic run_test(input test_t t);
        @(posedge clk_in);
        #2;
        test_name      = t.name;
        pending_digits = t.exp_digits;
        pending_en     = t.exp_en;
        if (t.extra[0]) press_key(KEY_PLUS);
        if (t.extra[1]) press_key(KEY_STRAY);
        for (int k = 0; k < int'(t.a_n); k++) begin
            press_key(digit_key(int'(t.a_keys[11 - 4*k -: 4])));
        end
        press_key(op_key(t.op));
        if (t.extra[2]) press_key(KEY_EQL);
        for (int k = 0; k < int'(t.b_n); k++) begin
            press_key(digit_key(int'(t.b_keys[11 - 4*k -: 4])));
        end
        press_key(KEY_EQL);
        wait (calc_done);
        repeat (2) @(posedge clk_in);
    endtask

    initial begin
        clk_in         = 1'b0;
        rst_n_in       = 1'b0;
        key_i          = KEY_IDLE;
        test_name      = "reset";
        check_entry    = 1'b0;
        exp_digits     = '0;
        exp_en         = '0;
        exp_done       = 1'b0;
        cycle_count    = 0;
        m_phase        = 0;
        m_count        = 0;
        m_done         = 1'b0;
        m_digits       = '0;
        m_res_digits   = '0;
        m_res_en       = '0;
        pending_digits = '0;
        pending_en     = '0;
        void'($urandom(32'h3299));

        tests[0]  = '{"entry_ignore", 2'd3, 12'h123, OP_ADD, 2'd1, 12'h500, 3'b111, 16'h0017, 4'b0011};
        tests[1]  = '{"add_zero",     2'd1, 12'h000, OP_ADD, 2'd1, 12'h000, 3'b000, 16'h0000, 4'b0001};
        tests[2]  = '{"add_carry",    2'd2, 12'h570, OP_ADD, 2'd2, 12'h680, 3'b011, 16'h0125, 4'b0111};
        tests[3]  = '{"mul_max",      2'd2, 12'h990, OP_MUL, 2'd2, 12'h990, 3'b000, 16'h9801, 4'b1111};
        tests[4]  = '{"mul_zero",     2'd1, 12'h000, OP_MUL, 2'd2, 12'h450, 3'b000, 16'h0000, 4'b0001};
        tests[5]  = '{"mul_mid",      2'd2, 12'h120, OP_MUL, 2'd2, 12'h340, 3'b000, 16'h0408, 4'b0111};
        tests[6]  = '{"sub_pos",      2'd2, 12'h470, OP_SUB, 2'd1, 12'h300, 3'b000, 16'h0044, 4'b0011};
        tests[7]  = '{"sub_neg",      2'd1, 12'h300, OP_SUB, 2'd2, 12'h470, 3'b100, 16'h0A44, 4'b0111};
        tests[8]  = '{"sub_zero",     2'd2, 12'h250, OP_SUB, 2'd2, 12'h250, 3'b000, 16'h0000, 4'b0001};
        tests[9]  = '{"sub_neg_big",  2'd1, 12'h100, OP_SUB, 2'd2, 12'h990, 3'b000, 16'h0A98, 4'b0111};
        tests[10] = '{"sub_neg_one",  2'd1, 12'h500, OP_SUB, 2'd1, 12'h600, 3'b000, 16'h00A1, 4'b0011};

        repeat (3) @(posedge clk_in);
        #2;
        rst_n_in = 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            run_test(tests[i]);
        end
        repeat (4) @(posedge clk_in);
        $display("summary: %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_passed, tests_failed, errors, i_dut.i_properties.assert_failures);
        if (tests_passed == N_TESTS && tests_failed == 0 && errors == 0 &&
            i_dut.i_properties.assert_failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/calc_pkg.sv
source/key_scanner.sv
source/operand_entry.sv
source/result_converter.sv
source/display_select.sv
source/calculator_top.sv
bench/calculator_properties.sv
bench/calculator_checker.sv
bench/calculator_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= calculator_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(wildcard source/*.sv bench/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
